// ==== aluExecUnit.f ====
hdl/aluPkg.sv
hdl/wbCmdPort.sv
hdl/operandDecode.sv
hdl/aluCore.sv
hdl/resultQueue.sv
hdl/aluExecUnit.sv
dv/aluExecUnitTb.sv

// ==== dv/aluExecUnitTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluExecUnitTb import aluPkg::*; ();

	localparam int respTimeout = 50; // Cycles per bus response
	localparam int pollLimit   = 20; // Status reads before giving up
	localparam int stallCycles = 20;

	logic                 clk;
	logic                 arstN;
	logic                 cyc;
	logic                 stb;
	logic                 we;
	logic [1:0]           adr;
	logic [dataWidth-1:0] datIn;
	logic [dataWidth-1:0] datOut;
	logic                 ack;
	logic                 err;
	logic [31:0]          rngState = 32'h4355071c;
	logic [dataWidth-1:0] expQ [$]; // Expected results in launch order

	majorOpE regOps [0:6] = '{opArith, opShift, opSeq, opSlt, opSle, opSco, opBtr};
	majorOpE immOps [0:24] = '{opAddi, opSubi, opOri, opAndi, opRoli, opSlli, opRori,
		opSrai, opSt, opLd, opStu, opSlbi, opLbi, opBeqz, opBnez, opBltz, opJ, opJr,
		opJal, opJalr, opRet, opHalt, opNop, opSiic, opRti};

	aluExecUnit DUT (.clk, .arstN, .cyc, .stb, .we, .adr, .datIn, .datOut, .ack, .err);

	always #50 clk = ~clk;

	task automatic failNow(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic checkEq(input string name, input logic [15:0] expVal,
			input logic [15:0] actVal);
		assert (actVal === expVal)
			else failNow($sformatf("ERROR %s expected 0x%04h actual 0x%04h", name, expVal, actVal));
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic drawRandom(output logic [31:0] value);
		rngState = xorshift32(rngState);
		value    = rngState;
	endtask

	// Reference model from the decode and ALU rules
	function automatic logic [15:0] modelResult(input logic [15:0] ins, input logic [15:0] a,
			input logic [15:0] rt);
		majorOpE     op;
		aluFnE       fn;
		logic [15:0] b;
		logic [15:0] r;
		logic [16:0] wide;
		logic [3:0]  s;
		op = majorOpE'(ins[15:11]);
		case (op) // Operand B
			opArith, opShift, opSeq, opSlt, opSle, opSco, opRet: b = rt;
			opAddi, opSubi, opSt, opLd, opStu: b = {{11{ins[4]}}, ins[4:0]};
			opOri, opAndi, opRoli, opSlli, opRori, opSrai: b = {11'd0, ins[4:0]};
			opBeqz, opBnez, opBltz, opLbi, opJr, opJalr: b = {{8{ins[7]}}, ins[7:0]};
			opSlbi: b = {8'd0, ins[7:0]};
			opJ, opJal: b = {{5{ins[10]}}, ins[10:0]}; // 11-bit displacement
			opHalt, opNop, opSiic, opRti: b = 16'd0;
			default: b = 16'd1; // BTR and unlisted codes
		endcase
		case (op) // ALU function
			opArith: fn = (ins[1:0] == 2'd0) ? fnAdd : (ins[1:0] == 2'd1) ? fnSub :
				(ins[1:0] == 2'd2) ? fnOr : fnAnd;
			opShift: fn = (ins[1:0] == 2'd0) ? fnRol : (ins[1:0] == 2'd1) ? fnSll :
				(ins[1:0] == 2'd2) ? fnRor : fnSra;
			opAddi, opSt, opLd, opStu, opJr, opJalr: fn = fnAdd;
			opSubi: fn = fnSub;
			opOri:  fn = fnOr;
			opAndi: fn = fnAnd;
			opRoli: fn = fnRol;
			opSlli: fn = fnSll;
			opRori: fn = fnRor;
			opSrai: fn = fnSra;
			opSeq:  fn = fnSeq;
			opSlt:  fn = fnSlt;
			opSle:  fn = fnSle;
			opSco:  fn = fnSco;
			opBtr:  fn = fnBtr;
			opSlbi: fn = fnSlbi;
			default: fn = fnPassB;
		endcase
		s    = b[3:0];
		wide = {1'b0, a} + {1'b0, b};
		case (fn)
			fnAdd:  r = a + b;
			fnSub:  r = b - a;
			fnOr:   r = a | b;
			fnAnd:  r = a & b;
			fnRol:  r = (a << s) | (a >> (16 - s));
			fnSll:  r = a << s;
			fnRor:  r = (a >> s) | (a << (16 - s));
			fnSra:  r = 16'($signed(a) >>> s);
			fnSeq:  r = (a == b) ? 16'd1 : 16'd0;
			fnSlt:  r = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
			fnSle:  r = ($signed(a) <= $signed(b)) ? 16'd1 : 16'd0;
			fnSco:  r = {15'd0, wide[16]};
			fnBtr: begin
				for (int i = 0; i < 16; i++) begin
					r[i] = a[15-i];
				end
			end
			fnSlbi: r = {a[7:0], 8'd0} | b;
			default: r = b;
		endcase
		return r;
	endfunction

	// One Wishbone classic cycle driven on the falling edge
	task automatic busCycle(input logic wr, input logic [1:0] a, input logic [15:0] d,
			output logic [15:0] rdData, output logic gotErr);
		int waited;
		waited = 0;
		@(negedge clk);
		cyc   = 1'b1;
		stb   = 1'b1;
		we    = wr;
		adr   = a;
		datIn = d;
		@(negedge clk);
		while (!(ack || err)) begin
			assert (waited < respTimeout) else failNow("Bus cycle got neither ack nor err in time");
			@(negedge clk);
			waited++;
		end
		rdData = datOut; // Registered on the ack edge
		gotErr = err;
		cyc    = 1'b0;
		stb    = 1'b0;
		we     = 1'b0;
	endtask

	task automatic writeReg(input logic [1:0] a, input logic [15:0] d);
		logic [15:0] unused;
		logic        gotErr;
		busCycle(1'b1, a, d, unused, gotErr);
		assert (!gotErr) else failNow("Register write was answered with err");
	endtask

	task automatic readReg(input logic [1:0] a, output logic [15:0] d);
		logic gotErr;
		busCycle(1'b0, a, 16'd0, d, gotErr);
		assert (!gotErr) else failNow("Register read was answered with err");
	endtask

	// Poll status until enough results sit in the queue
	task automatic waitForResults(input int need, output logic [15:0] status);
		int polls;
		polls = 0;
		readReg(2'd0, status);
		while (status < need) begin
			assert (polls < pollLimit) else failNow("Results never showed up in the queue");
			readReg(2'd0, status);
			polls++;
		end
	endtask

	task automatic popCheck(input string name);
		logic [15:0] status;
		logic [15:0] value;
		waitForResults(1, status);
		readReg(2'd3, value);
		checkEq(name, expQ.pop_front(), value);
	endtask

	task automatic issueInstr(input majorOpE op);
		logic [31:0] rs;
		logic [31:0] rt;
		logic [31:0] lo;
		logic [15:0] ins;
		drawRandom(rs);
		drawRandom(rt);
		drawRandom(lo);
		ins = {op, lo[10:0]}; // Random immediate bits
		writeReg(2'd0, rs[15:0]);
		writeReg(2'd1, rt[15:0]);
		writeReg(2'd2, ins);
		expQ.push_back(modelResult(ins, rs[15:0], rt[15:0]));
	endtask

	// Instruction write left unanswered and then abandoned
	task automatic stalledWrite(input logic [15:0] ins);
		@(negedge clk);
		cyc   = 1'b1;
		stb   = 1'b1;
		we    = 1'b1;
		adr   = 2'd2;
		datIn = ins;
		repeat (stallCycles) begin
			@(negedge clk);
			assert (!ack && !err) else failNow("Instruction write answered while queue full");
		end
		cyc = 1'b0;
		stb = 1'b0;
		we  = 1'b0;
	endtask

	initial begin
		repeat (100000) @(posedge clk);
		failNow("Simulation watchdog expired");
	end

	initial begin
		logic [31:0] r;
		logic [31:0] rs;
		logic [31:0] rt;
		logic [15:0] ins;
		logic [15:0] value;
		logic        gotErr;
		clk   = 1'b0;
		arstN = 1'b0;
		cyc   = 1'b0;
		stb   = 1'b0;
		we    = 1'b0;
		adr   = 2'd0;
		datIn = '0;
		repeat (5) @(negedge clk);
		arstN = 1'b1;
		@(negedge clk);

		// Idle after reset
		assert (!ack && !err) else failNow("ack or err high before any bus cycle");
		readReg(2'd0, value);
		checkEq("reset", 16'd0, value);

		for (int n = 0; n < 40; n++) begin
			drawRandom(r);
			issueInstr(regOps[r % 7]);
			popCheck("regFormat");
		end

		for (int n = 0; n < 60; n++) begin
			drawRandom(r);
			issueInstr(immOps[r % 25]);
			popCheck("immediate");
		end

		// Four in flight and read back in order
		for (int n = 0; n < 4; n++) begin
			drawRandom(r);
			issueInstr(regOps[r % 7]);
		end
		waitForResults(4, value);
		checkEq("queueFill", 16'd4, value);
		repeat (4) popCheck("queueFill");

		// Fill again so the fifth write waits for a free slot
		for (int n = 0; n < 4; n++) begin
			drawRandom(r);
			issueInstr(immOps[r % 25]);
		end
		drawRandom(rs);
		drawRandom(rt);
		drawRandom(r);
		ins = {regOps[r % 7], r[26:16]};
		writeReg(2'd0, rs[15:0]);
		writeReg(2'd1, rt[15:0]);
		stalledWrite(ins);
		popCheck("backPressure");
		writeReg(2'd2, ins);
		expQ.push_back(modelResult(ins, rs[15:0], rt[15:0]));
		repeat (4) popCheck("backPressure");

		// Pop with nothing queued
		busCycle(1'b0, 2'd3, 16'd0, value, gotErr);
		assert (gotErr) else failNow("Pop on empty queue was acknowledged instead of err");
		readReg(2'd0, value);
		checkEq("emptyPop", 16'd0, value);

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/aluCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluCore import aluPkg::*; (
	input  wire                  clk,
	input  wire                  arstN,
	input  wire                  issue,
	input  wire  [dataWidth-1:0] opA,
	input  wire  [dataWidth-1:0] opB,
	input  wire  aluFnE          aluFn,
	output logic [dataWidth-1:0] result,
	output logic                 resultValid
);

	logic [dataWidth-1:0]   aluOut;
	logic [dataWidth:0]     sum; // Top bit is carry out
	logic [3:0]             shAmt;
	logic [2*dataWidth-1:0] rotL; // Upper half is A rotated left
	logic [2*dataWidth-1:0] rotR; // Lower half is A rotated right

	assign sum   = {1'b0, opA} + {1'b0, opB};
	assign shAmt = opB[3:0];
	assign rotL  = {opA, opA} << shAmt;
	assign rotR  = {opA, opA} >> shAmt;

	always_comb begin
		aluOut = opB;
		case (aluFn)
			fnAdd:  aluOut = sum[dataWidth-1:0];
			fnSub:  aluOut = opB - opA; // WISC subtracts Rs from the other operand
			fnOr:   aluOut = opA | opB;
			fnAnd:  aluOut = opA & opB;
			fnRol:  aluOut = rotL[2*dataWidth-1:dataWidth];
			fnSll:  aluOut = opA << shAmt;
			fnRor:  aluOut = rotR[dataWidth-1:0];
			fnSra:  aluOut = $signed(opA) >>> shAmt;
			fnSeq:  aluOut = {{(dataWidth-1){1'b0}}, opA == opB};
			fnSlt:  aluOut = {{(dataWidth-1){1'b0}}, $signed(opA) < $signed(opB)};
			fnSle:  aluOut = {{(dataWidth-1){1'b0}}, $signed(opA) <= $signed(opB)};
			fnSco:  aluOut = {{(dataWidth-1){1'b0}}, sum[dataWidth]};
			fnBtr: begin
				for (int i = 0; i < dataWidth; i++) begin
					aluOut[i] = opA[dataWidth-1-i]; // Mirror bits
				end
			end
			fnSlbi: aluOut = (opA << 8) | opB;
			default: aluOut = opB; // fnPassB
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			resultValid <= 1'b0;
		end else begin
			resultValid <= issue; // One cycle behind issue
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			result <= aluOut;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/aluExecUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluExecUnit import aluPkg::*; #(
	parameter int queueDepth = 4 // Result slots
) (
	input  wire                  clk,
	input  wire                  arstN,
	input  wire                  cyc,
	input  wire                  stb,
	input  wire                  we,
	input  wire  [1:0]           adr,
	input  wire  [dataWidth-1:0] datIn,
	output logic [dataWidth-1:0] datOut,
	output logic                 ack,
	output logic                 err
);

	logic [dataWidth-1:0] instr;
	logic [dataWidth-1:0] rsVal;
	logic [dataWidth-1:0] rtVal;
	logic [dataWidth-1:0] opA;
	logic [dataWidth-1:0] opB;
	aluFnE                aluFn;
	logic                 launch; // Also the ALU issue strobe
	logic                 pop;
	logic [dataWidth-1:0] result;
	logic                 resultValid;
	logic                 full;
	logic                 empty;
	logic [dataWidth-1:0] count;
	logic [dataWidth-1:0] headData;

	wbCmdPort cmdPort (
		.clk, .arstN, .cyc, .stb, .we, .adr, .datIn,
		.full, .empty, .count, .headData,
		.datOut, .ack, .err, .instr, .rsVal, .rtVal, .launch, .pop
	);

	operandDecode decode (.instr, .rsVal, .rtVal, .opA, .opB, .aluFn);

	aluCore alu (
		.clk, .arstN, .issue(launch), .opA, .opB, .aluFn,
		.result, .resultValid
	);

	resultQueue #(.queueDepth(queueDepth)) queue (
		.clk, .arstN, .launch, .resultValid, .result, .pop,
		.full, .empty, .count, .headData
	);

endmodule

`default_nettype wire

// ==== hdl/aluPkg.sv ====
`default_nettype none

package aluPkg;

	localparam int dataWidth = 16; // Fixed by the ISA

	// Major opcode, instr[15:11]
	typedef enum logic [4:0] {
		opHalt  = 5'b00000,
		opNop   = 5'b00001,
		opSiic  = 5'b00010,
		opRti   = 5'b00011,
		opJ     = 5'b00100,
		opJr    = 5'b00101,
		opJal   = 5'b00110,
		opJalr  = 5'b00111,
		opAddi  = 5'b01000,
		opSubi  = 5'b01001,
		opOri   = 5'b01010,
		opAndi  = 5'b01011,
		opBeqz  = 5'b01100,
		opBnez  = 5'b01101,
		opRet   = 5'b01110,
		opBltz  = 5'b01111,
		opSt    = 5'b10000,
		opLd    = 5'b10001,
		opSlbi  = 5'b10010,
		opStu   = 5'b10011,
		opRoli  = 5'b10100,
		opSlli  = 5'b10101,
		opRori  = 5'b10110,
		opSrai  = 5'b10111,
		opLbi   = 5'b11000,
		opBtr   = 5'b11001,
		opShift = 5'b11010, // Funct in instr[1:0]
		opArith = 5'b11011, // Funct in instr[1:0]
		opSeq   = 5'b11100,
		opSlt   = 5'b11101,
		opSle   = 5'b11110,
		opSco   = 5'b11111
	} majorOpE;

	typedef enum logic [3:0] {
		fnAdd, fnSub, fnOr, fnAnd,
		fnRol, fnSll, fnRor, fnSra,
		fnSeq, fnSlt, fnSle, fnSco,
		fnBtr, fnSlbi, fnPassB
	} aluFnE;

endpackage

`default_nettype wire

// ==== hdl/operandDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module operandDecode import aluPkg::*; (
	input  wire  [dataWidth-1:0] instr,
	input  wire  [dataWidth-1:0] rsVal,
	input  wire  [dataWidth-1:0] rtVal,
	output logic [dataWidth-1:0] opA,
	output logic [dataWidth-1:0] opB,
	output aluFnE                aluFn
);

	majorOpE              op;
	logic [dataWidth-1:0] immS5; // Sign extended 5-bit immediate
	logic [dataWidth-1:0] immZ5;
	logic [dataWidth-1:0] immS8;
	logic [dataWidth-1:0] immZ8;
	logic [dataWidth-1:0] dispS11; // Jump displacement

	assign op      = majorOpE'(instr[15:11]);
	assign opA     = rsVal; // SLBI too, ALU does the shift
	assign immS5   = {{(dataWidth-5){instr[4]}}, instr[4:0]};
	assign immZ5   = {{(dataWidth-5){1'b0}}, instr[4:0]};
	assign immS8   = {{(dataWidth-8){instr[7]}}, instr[7:0]};
	assign immZ8   = {{(dataWidth-8){1'b0}}, instr[7:0]};
	assign dispS11 = {{(dataWidth-11){instr[10]}}, instr[10:0]};

	always_comb begin
		opB   = {{(dataWidth-1){1'b0}}, 1'b1}; // Undefined codes get 1
		aluFn = fnPassB;
		case (op)
			opArith: begin
				opB = rtVal;
				case (instr[1:0])
					2'b00: aluFn = fnAdd;
					2'b01: aluFn = fnSub;
					2'b10: aluFn = fnOr;
					2'b11: aluFn = fnAnd;
				endcase
			end
			opShift: begin
				opB = rtVal;
				case (instr[1:0])
					2'b00: aluFn = fnRol;
					2'b01: aluFn = fnSll;
					2'b10: aluFn = fnRor;
					2'b11: aluFn = fnSra;
				endcase
			end
			opSeq, opSlt, opSle, opSco: begin
				opB   = rtVal;
				aluFn = aluFnE'({2'b10, instr[12:11]}); // fnSeq..fnSco in opcode order
			end
			opAddi, opSt, opLd, opStu: begin
				opB   = immS5; // Address or sum offset
				aluFn = fnAdd;
			end
			opSubi: begin
				opB   = immS5;
				aluFn = fnSub;
			end
			opOri: begin
				opB   = immZ5;
				aluFn = fnOr;
			end
			opAndi: begin
				opB   = immZ5;
				aluFn = fnAnd;
			end
			opRoli, opSlli, opRori, opSrai: begin
				opB   = immZ5;
				aluFn = aluFnE'({2'b01, instr[12:11]}); // fnRol..fnSra
			end
			opBeqz, opBnez, opBltz, opLbi: opB = immS8; // Passed through
			opJr, opJalr: begin
				opB   = immS8; // Rs plus offset
				aluFn = fnAdd;
			end
			opSlbi: begin
				opB   = immZ8;
				aluFn = fnSlbi;
			end
			opJ, opJal: opB = dispS11;
			opBtr: aluFn = fnBtr; // opB stays 1, unused
			opRet: opB = rtVal;
			opHalt, opNop, opSiic, opRti: opB = '0;
			default: ; // Undefined
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/resultQueue.sv ====
`timescale 1ns/1ps
`default_nettype none

module resultQueue import aluPkg::*; #(
	parameter int queueDepth = 4
) (
	input  wire                  clk,
	input  wire                  arstN,
	input  wire                  launch,
	input  wire                  resultValid,
	input  wire  [dataWidth-1:0] result,
	input  wire                  pop,
	output logic                 full,
	output logic                 empty,
	output logic [dataWidth-1:0] count,
	output logic [dataWidth-1:0] headData
);

	localparam int ptrW = $clog2(queueDepth);
	localparam int cntW = $clog2(queueDepth + 1);
	localparam logic [cntW-1:0] depthC   = cntW'(queueDepth);
	localparam logic [ptrW-1:0] lastSlot = ptrW'(queueDepth - 1);

	logic [dataWidth-1:0] mem [queueDepth];
	logic [ptrW-1:0]      wrPtr;
	logic [ptrW-1:0]      rdPtr;
	logic [cntW-1:0]      reserved; // Stored plus in flight
	logic [cntW-1:0]      stored;

	assign full     = (reserved == depthC);
	assign empty    = (stored == '0);
	assign count    = dataWidth'(stored);
	assign headData = mem[rdPtr];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wrPtr    <= '0;
			rdPtr    <= '0;
			reserved <= '0;
			stored   <= '0;
		end else begin
			if (resultValid) begin
				wrPtr <= (wrPtr == lastSlot) ? '0 : wrPtr + 1'b1; // Wrap at depth
			end
			if (pop) begin
				rdPtr <= (rdPtr == lastSlot) ? '0 : rdPtr + 1'b1;
			end
			if (launch && !pop) reserved <= reserved + 1'b1;
			else if (pop && !launch) reserved <= reserved - 1'b1;
			if (resultValid && !pop) stored <= stored + 1'b1;
			else if (pop && !resultValid) stored <= stored - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (resultValid) begin
			mem[wrPtr] <= result;
		end
	end

	// Reservation must keep every in-flight result in a free slot
	noOverflow: assert property (@(posedge clk) disable iff (!arstN)
		resultValid |-> stored != depthC);
	noUnderflow: assert property (@(posedge clk) disable iff (!arstN) pop |-> !empty);

endmodule

`default_nettype wire

// ==== hdl/wbCmdPort.sv ====
`timescale 1ns/1ps
`default_nettype none

module wbCmdPort import aluPkg::*; (
	input  wire                  clk,
	input  wire                  arstN,
	input  wire                  cyc,
	input  wire                  stb,
	input  wire                  we,
	input  wire  [1:0]           adr,
	input  wire  [dataWidth-1:0] datIn,
	input  wire                  full,
	input  wire                  empty,
	input  wire  [dataWidth-1:0] count,
	input  wire  [dataWidth-1:0] headData,
	output logic [dataWidth-1:0] datOut,
	output logic                 ack,
	output logic                 err,
	output logic [dataWidth-1:0] instr,
	output logic [dataWidth-1:0] rsVal,
	output logic [dataWidth-1:0] rtVal,
	output logic                 launch,
	output logic                 pop
);

	logic cmdSeen; // Cycle pending, not yet answered
	logic wrCmd;
	logic rdCmd;
	logic instrStall; // Instruction write held off by full queue

	assign cmdSeen    = cyc && stb && !ack && !err;
	assign wrCmd      = cmdSeen && we;
	assign rdCmd      = cmdSeen && !we;
	assign instrStall = wrCmd && (adr == 2'd2) && full;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			ack    <= 1'b0;
			err    <= 1'b0;
			launch <= 1'b0;
			pop    <= 1'b0;
		end else begin
			ack    <= (wrCmd && !instrStall) || (rdCmd && !(adr == 2'd3 && empty));
			err    <= rdCmd && (adr == 2'd3) && empty; // Pop on empty queue
			launch <= wrCmd && (adr == 2'd2) && !full;
			pop    <= rdCmd && (adr == 2'd3) && !empty;
		end
	end

	// Operand, instruction and read data registers
	always_ff @(posedge clk) begin
		if (wrCmd) begin
			case (adr)
				2'd0: rsVal <= datIn;
				2'd1: rtVal <= datIn;
				2'd2: if (!full) instr <= datIn; // Captured on the ack edge
				default: ; // Ignored write
			endcase
		end
		if (rdCmd) begin
			case (adr)
				2'd0:    datOut <= count; // Results waiting
				2'd3:    datOut <= headData;
				default: datOut <= '0;
			endcase
		end
	end

	ackErrExclusive: assert property (@(posedge clk) disable iff (!arstN) !(ack && err));
	respNeedsStb: assert property (@(posedge clk) disable iff (!arstN)
		(ack || err) |-> $past(cyc && stb));

endmodule

`default_nettype wire
